//--- compile.f
dm_pkg.sv
tick_gen.sv
countdown_ctrl.sv
glyph_rom.sv
row_scanner.sv
countdown_display.sv
tb_clock.sv
countdown_display_tb.sv

//--- countdown_display_tb.sv
`timescale 1ns/1ps

module countdown_display_tb #(
    parameter int SCAN_DIV    = 4,
    parameter int STEP_FRAMES = 2,
    parameter int NUM_RUNS    = 7
);

    typedef struct packed {
        logic [15:0] hi_clocks;
        logic [15:0] lo_clocks;
    } run_t;

    logic         clk;
    logic         rst;
    logic         st;
    logic [7:0]   row;
    dm_pkg::col_t colr;
    dm_pkg::col_t colg;
    int           errors;
    int           checks;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    countdown_display #(
        .SCAN_DIV    (SCAN_DIV),
        .STEP_FRAMES (STEP_FRAMES)
    ) uut (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

    // Clocks with st high, then clocks with st low. A full countdown to 0 takes 389 clocks.
    function automatic run_t stim_entry(input int idx);
        run_t entry;
        case (idx)
            0: entry = '{hi_clocks: 16'd5, lo_clocks: 16'd3};
            1: entry = '{hi_clocks: 16'd30, lo_clocks: 16'd4};
            2: entry = '{hi_clocks: 16'd150, lo_clocks: 16'd6};   // Drops during digit 4.
            3: entry = '{hi_clocks: 16'd500, lo_clocks: 16'd10};  // Holds 0 for a while.
            4: entry = '{hi_clocks: 16'd3, lo_clocks: 16'd2};
            5: entry = '{hi_clocks: 16'd390, lo_clocks: 16'd8};
            default: entry = '{hi_clocks: 16'd70, lo_clocks: 16'd12};
        endcase
        return entry;
    endfunction

    // Eight rows per digit, row 0 in the top byte.
    function automatic dm_pkg::col_t glyph_shape(input int d, input int r);
        logic [63:0] bits;
        case (d)
            6: bits = 64'h78CC0C1830003000;
            5: bits = 64'h007E607C0606663C;
            4: bits = 64'h000C1C2C4C7E0C0C;
            3: bits = 64'h003C66061C06663C;
            2: bits = 64'h003C66060C30607E;
            1: bits = 64'h001818381818187E;
            default: bits = 64'h003C42424242423C;
        endcase
        return bits[63 - 8 * r -: 8];
    endfunction

    function automatic dm_pkg::pixel_row_t model_pixel(input int d, input int r);
        dm_pkg::pixel_row_t pix;
        pix = '0;
        if (d >= 4)
            pix.red = glyph_shape(d, r);
        else if (d >= 2)
        begin
            pix.red   = glyph_shape(d, r); // Yellow lights both planes.
            pix.green = glyph_shape(d, r);
        end
        else
            pix.green = glyph_shape(d, r);
        return pix;
    endfunction

    function automatic int count_low_bits(input logic [7:0] value);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++)
            if (value[i] == 1'b0)
                n++;
        return n;
    endfunction

    // Expected outputs after the c-th rising edge since st was driven high.
    task automatic check_cycle(input int c, input int hi);
        int                 ticks;
        int                 n;
        int                 d;
        logic [7:0]         exp_row;
        dm_pkg::pixel_row_t exp_pix;
        exp_row = 8'hFF;
        exp_pix = '0;
        d = -1;
        ticks = (c >= 1 && c <= hi) ? (c - 1) / SCAN_DIV : 0;
        if (ticks > 0)
        begin
            n = ticks - 1;
            d = 6 - n / (STEP_FRAMES * 8);
            if (d < 0)
                d = 0;
            exp_row = ~(8'b1 << (n % 8));
            exp_pix = model_pixel(d, n % 8);
        end
        checks++;
        assert (count_low_bits(row) <= 1)
        else
        begin
            errors++;
            $display("At %0t the row drive %b has more than one row low.", $time, row);
        end
        assert (row === exp_row)
        else
        begin
            errors++;
            $display("MISMATCH at %0t: row expected %b, got %b", $time, exp_row, row);
        end
        assert (colr === exp_pix.red)
        else
        begin
            errors++;
            $display("MISMATCH at %0t: colr expected %b, got %b", $time, exp_pix.red, colr);
        end
        assert (colg === exp_pix.green)
        else
        begin
            errors++;
            $display("MISMATCH at %0t: colg expected %b, got %b", $time, exp_pix.green, colg);
        end
        if (d >= 0)
        begin
            assert ((d <= 3 || colg == '0) && (d >= 2 || colr == '0)
                    && (d > 3 || d < 2 || colr == colg))
            else
            begin
                errors++;
                $display("At %0t digit %0d shows the wrong colour: colr %b, colg %b.",
                         $time, d, colr, colg);
            end
        end
    endtask

    initial
    begin : watchdog
        int   budget;
        run_t entry;
        budget = 16 + 4 + 100; // Reset, idle checks and some slack.
        for (int i = 0; i < NUM_RUNS; i++)
        begin
            entry = stim_entry(i);
            budget = budget + entry.hi_clocks + entry.lo_clocks;
        end
        #(budget * 10);
        $display("Timeout: the run did not end within %0d clocks.", budget);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin : main
        run_t entry;
        int   hi;
        int   total;
        st = 1'b0;
        errors = 0;
        checks = 0;

        // Outputs stay blank through reset and while st is low.
        @(negedge clk);
        while (rst)
        begin
            check_cycle(0, 0);
            @(negedge clk);
        end
        repeat (4)
        begin
            @(posedge clk);
            st <= 1'b0;
            @(negedge clk);
            check_cycle(0, 0);
        end

        for (int i = 0; i < NUM_RUNS; i++)
        begin
            entry = stim_entry(i);
            hi = entry.hi_clocks;
            total = entry.hi_clocks + entry.lo_clocks;
            for (int c = 0; c < total; c++)
            begin
                @(posedge clk);
                st <= (c < hi);
                @(negedge clk);
                check_cycle(c, hi);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0; // Released on a rising edge like any other stimulus.
    end

endmodule

//--- countdown_display.sv
`timescale 1ns/1ps

module countdown_display #(
    parameter int SCAN_DIV    = dm_pkg::DEF_SCAN_DIV,
    parameter int STEP_FRAMES = dm_pkg::DEF_STEP_FRAMES
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        st,
    output logic [dm_pkg::NUM_ROWS-1:0] row,
    output dm_pkg::col_t                colr,
    output dm_pkg::col_t                colg
);

    logic               run;
    logic               scan_tick;
    logic               step_tick;
    dm_pkg::digit_t     digit;
    dm_pkg::row_idx_t   next_row;
    dm_pkg::pixel_row_t pix;

    tick_gen #(
        .SCAN_DIV    (SCAN_DIV),
        .STEP_FRAMES (STEP_FRAMES)
    ) u_tick_gen (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .scan_tick (scan_tick),
        .step_tick (step_tick)
    );

    countdown_ctrl u_countdown_ctrl (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .step_tick (step_tick),
        .digit     (digit),
        .run       (run)
    );

    glyph_rom u_glyph_rom (
        .digit   (digit),
        .row_sel (next_row), // Looked up one row ahead of the registered drive.
        .pix     (pix)
    );

    row_scanner u_row_scanner (
        .clk       (clk),
        .rst       (rst),
        .active    (run),
        .scan_tick (scan_tick),
        .pix       (pix),
        .next_row  (next_row),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

endmodule

//--- row_scanner.sv
`timescale 1ns/1ps

module row_scanner (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         active,
    input  logic                         scan_tick,
    input  dm_pkg::pixel_row_t           pix,
    output dm_pkg::row_idx_t             next_row,
    output logic [dm_pkg::NUM_ROWS-1:0]  row,
    output dm_pkg::col_t                 colr,
    output dm_pkg::col_t                 colg
);

    dm_pkg::row_idx_t row_idx;

    // Wraps from 7 to 0 by the width of the index alone.
    assign next_row = row_idx + 3'd1;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= 3'd7;
            row     <= '1;
            colr    <= '0;
            colg    <= '0;
        end
        else if (!active)
        begin
            row_idx <= 3'd7; // The first tick after a start then selects row 0.
            row     <= '1;
            colr    <= '0;
            colg    <= '0;
        end
        else if (scan_tick)
        begin
            row_idx <= next_row;
            row     <= ~(dm_pkg::NUM_ROWS'(1) << next_row);
            colr    <= pix.red;
            colg    <= pix.green;
        end
    end

    // Once a row is lit, each tick moves the low bit one row on, wrapping from 7 to 0.
    a_row_walk: assert property (@(posedge clk) disable iff (rst)
        (active && scan_tick && !(&row)) |=>
            (row == $past({row[dm_pkg::NUM_ROWS-2:0], row[dm_pkg::NUM_ROWS-1]})));

endmodule

//--- glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom (
    input  dm_pkg::digit_t     digit,
    input  dm_pkg::row_idx_t   row_sel,
    output dm_pkg::pixel_row_t pix
);

    dm_pkg::col_t shape;

    // Every digit has a single shape; the colour only decides which planes light.
    always_comb
    begin
        shape = '0;
        case (digit)
            3'd6:
                case (row_sel)
                    3'd0: shape = 8'b0111_1000;
                    3'd1: shape = 8'b1100_1100;
                    3'd2: shape = 8'b0000_1100;
                    3'd3: shape = 8'b0001_1000;
                    3'd4: shape = 8'b0011_0000;
                    3'd6: shape = 8'b0011_0000;
                    default: shape = 8'b0000_0000; // Rows 5 and 7 stay dark.
                endcase
            3'd5:
                case (row_sel)
                    3'd1: shape = 8'b0111_1110;
                    3'd2: shape = 8'b0110_0000;
                    3'd3: shape = 8'b0111_1100;
                    3'd4, 3'd5: shape = 8'b0000_0110;
                    3'd6: shape = 8'b0110_0110;
                    3'd7: shape = 8'b0011_1100;
                    default: shape = 8'b0000_0000;
                endcase
            3'd4:
                case (row_sel)
                    3'd1, 3'd6, 3'd7: shape = 8'b0000_1100;
                    3'd2: shape = 8'b0001_1100;
                    3'd3: shape = 8'b0010_1100;
                    3'd4: shape = 8'b0100_1100;
                    3'd5: shape = 8'b0111_1110;
                    default: shape = 8'b0000_0000;
                endcase
            3'd3:
                case (row_sel)
                    3'd1, 3'd7: shape = 8'b0011_1100;
                    3'd2, 3'd6: shape = 8'b0110_0110;
                    3'd3, 3'd5: shape = 8'b0000_0110;
                    3'd4: shape = 8'b0001_1100;
                    default: shape = 8'b0000_0000;
                endcase
            3'd2:
                case (row_sel)
                    3'd1: shape = 8'b0011_1100;
                    3'd2: shape = 8'b0110_0110;
                    3'd3: shape = 8'b0000_0110;
                    3'd4: shape = 8'b0000_1100;
                    3'd5: shape = 8'b0011_0000;
                    3'd6: shape = 8'b0110_0000;
                    3'd7: shape = 8'b0111_1110;
                    default: shape = 8'b0000_0000;
                endcase
            3'd1:
                case (row_sel)
                    3'd3: shape = 8'b0011_1000;
                    3'd7: shape = 8'b0111_1110;
                    3'd0: shape = 8'b0000_0000;
                    default: shape = 8'b0001_1000;
                endcase
            3'd0:
                case (row_sel)
                    3'd1, 3'd7: shape = 8'b0011_1100;
                    3'd0: shape = 8'b0000_0000;
                    default: shape = 8'b0100_0010;
                endcase
            default: shape = '0;
        endcase
    end

    // Red for 6 to 2, green for 3 to 0, so 3 and 2 come out yellow.
    assign pix.red   = (digit >= 3'd2 && digit <= 3'd6) ? shape : '0;
    assign pix.green = (digit <= 3'd3) ? shape : '0;

endmodule

//--- countdown_ctrl.sv
`timescale 1ns/1ps

module countdown_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           st,
    input  logic           step_tick,
    output dm_pkg::digit_t digit,
    output logic           run
);

    dm_pkg::ctrl_state_t state;

    // St is folded in here so that the dividers and the display stop on the
    // same edge that takes the state back to IDLE.
    assign run = st && (state != dm_pkg::IDLE);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= dm_pkg::IDLE;
            digit <= dm_pkg::DIGIT_BLANK;
        end
        else if (!st)
        begin
            state <= dm_pkg::IDLE;
            digit <= dm_pkg::DIGIT_BLANK;
        end
        else
        begin
            case (state)
                dm_pkg::IDLE:
                begin
                    state <= dm_pkg::COUNT;
                    digit <= dm_pkg::DIGIT_START;
                end
                dm_pkg::COUNT:
                begin
                    if (step_tick)
                    begin
                        if (digit == 3'd0)
                            state <= dm_pkg::HOLD; // Zero stays up until st drops.
                        else
                            digit <= digit - 3'd1;
                    end
                end
                dm_pkg::HOLD:
                begin
                    digit <= 3'd0;
                end
                default:
                begin
                    state <= dm_pkg::IDLE;
                    digit <= dm_pkg::DIGIT_BLANK;
                end
            endcase
        end
    end

    // The blank code is only legal while nothing is being counted.
    a_no_blank_active: assert property (@(posedge clk) disable iff (rst)
        (state != dm_pkg::IDLE) |-> (digit != dm_pkg::DIGIT_BLANK));

endmodule

//--- tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
    parameter int SCAN_DIV    = dm_pkg::DEF_SCAN_DIV,
    parameter int STEP_FRAMES = dm_pkg::DEF_STEP_FRAMES
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic scan_tick,
    output logic step_tick
);

    localparam int DIV_W = $clog2(SCAN_DIV + 1);
    localparam int STEP_TICKS = STEP_FRAMES * dm_pkg::NUM_ROWS;
    localparam int FRM_W = $clog2(STEP_TICKS + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);
    localparam logic [FRM_W-1:0] FRM_LAST = FRM_W'(STEP_TICKS - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [FRM_W-1:0] frm_cnt; // Scan ticks since the last step.

    assign scan_tick = run && (div_cnt == DIV_LAST);
    assign step_tick = scan_tick && (frm_cnt == FRM_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            frm_cnt <= '0;
        end
        else if (!run)
        begin
            div_cnt <= '0; // Restart so that every countdown begins on a full row.
            frm_cnt <= '0;
        end
        else
        begin
            if (scan_tick)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;

            if (step_tick)
                frm_cnt <= '0;
            else if (scan_tick)
                frm_cnt <= frm_cnt + 1'b1;
        end
    end

    // Neither divider ever counts past its last value.
    a_counts_in_range: assert property (@(posedge clk) disable iff (rst)
        (div_cnt <= DIV_LAST) && (frm_cnt <= FRM_LAST));

endmodule

//--- dm_pkg.sv
package dm_pkg;

    localparam int GLYPH_W  = 8;
    localparam int NUM_ROWS = 8;

    // Row period in clocks and frames per digit, for 50 MHz and a 1 kHz row rate.
    localparam int DEF_SCAN_DIV    = 50000;
    localparam int DEF_STEP_FRAMES = 125;

    typedef logic [2:0] row_idx_t;
    typedef logic [2:0] digit_t;
    typedef logic [GLYPH_W-1:0] col_t; // Bit 7 is the leftmost column.

    localparam digit_t DIGIT_START = 3'd6;
    localparam digit_t DIGIT_BLANK = 3'd7;

    // One row of both colour planes, as it goes to the column drivers.
    typedef struct packed {
        col_t red;
        col_t green;
    } pixel_row_t;

    typedef enum logic [1:0] {
        IDLE,
        COUNT,
        HOLD
    } ctrl_state_t;

endpackage
